// File: logic/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------
`define XLEN            32
`define IM_ADDR_LEN     32
`define IM_DATA_LEN     32
`define DM_ADDR_LEN     32
`define CSR_ADDR_LEN    12

// ----------------------------------------
// Fixed addresses
// ----------------------------------------
`define TRAP_VECTOR     32'h8000_0004    // Single M-mode handler.
`define RESET_PC        32'h8000_0000    // First fetch after reset.

`endif

// File: logic/cpu_types_pkg.sv
package cpu_types_pkg;

`include "cpu_params.svh"

// ----------------------------------------
// Privilege and exception codes
// ----------------------------------------
typedef enum logic [1:0] {
    PRV_U = 2'd0,
    PRV_S = 2'd1,
    PRV_H = 2'd2,
    PRV_M = 2'd3
} prv_e;

typedef enum logic [4:0] {
    EXC_INST_MISALIGNED  = 5'd0,
    EXC_INST_XES_FAULT   = 5'd1,
    EXC_ILL_INST         = 5'd2,
    EXC_BREAKPOINT       = 5'd3,
    EXC_LOAD_MISALIGNED  = 5'd4,
    EXC_LOAD_XES_FAULT   = 5'd5,
    EXC_STORE_MISALIGNED = 5'd6,
    EXC_STORE_XES_FAULT  = 5'd7,
    EXC_ECALL_U          = 5'd8,
    EXC_ECALL_S          = 5'd9,
    EXC_ECALL_H          = 5'd10,
    EXC_ECALL_M          = 5'd11,
    EXC_INST_PG_FAULT    = 5'd12,
    EXC_LOAD_PG_FAULT    = 5'd13,
    EXC_RSVD_14          = 5'd14,
    EXC_STORE_PG_FAULT   = 5'd15
} exc_code_e;

// ----------------------------------------
// Retire record
// ----------------------------------------
typedef struct packed {
    logic inst_misaligned;
    logic inst_pg_fault;
    logic inst_xes_fault;
    logic load_misaligned;
    logic load_pg_fault;
    logic load_xes_fault;
    logic store_misaligned;
    logic store_pg_fault;
    logic store_xes_fault;
} fault_flags_t;

typedef struct packed {
    logic [`IM_DATA_LEN-1:0] inst;
    logic [`IM_ADDR_LEN-1:0] exe_pc;
    logic [`IM_ADDR_LEN-1:0] wb_pc;
    logic [`IM_ADDR_LEN-1:0] inst_misaligned_epc;
    logic [`IM_ADDR_LEN-1:0] inst_badaddr;
    logic [`DM_ADDR_LEN-1:0] ldst_badaddr;
    logic [`XLEN-1:0]        rs1_data;
    logic                    is_ldst;        // Record comes from the memory stage.
    fault_flags_t            flags;
} retire_rec_t;

// Decoded system operation.
typedef struct packed {
    logic                     ecall;
    logic                     ebreak;
    logic                     mret;
    logic                     sret;
    logic                     sfence;
    logic                     csr_wr;
    logic [`CSR_ADDR_LEN-1:0] csr_addr;
    logic                     ill_inst;
    logic                     csr_ill;
    prv_e                     prv_req;
} sys_op_t;

endpackage

// File: logic/csr_pkg.sv
package csr_pkg;

`include "cpu_params.svh"

// ----------------------------------------
// Implemented CSR addresses
// ----------------------------------------
localparam logic [`CSR_ADDR_LEN-1:0] CSR_MSTATUS = 12'h300;
localparam logic [`CSR_ADDR_LEN-1:0] CSR_MEPC    = 12'h341;
localparam logic [`CSR_ADDR_LEN-1:0] CSR_MCAUSE  = 12'h342;
localparam logic [`CSR_ADDR_LEN-1:0] CSR_MTVAL   = 12'h343;
localparam logic [`CSR_ADDR_LEN-1:0] CSR_SATP    = 12'h180;

// ----------------------------------------
// mstatus layout
// ----------------------------------------
typedef struct packed {
    logic [31:23] rsvd_31_23;
    logic         tsr;            // Trap sret below M.
    logic         rsvd_21;
    logic         tvm;            // Trap satp and sfence below M.
    logic [19:13] rsvd_19_13;
    logic [1:0]   mpp;            // Privilege before the last trap.
    logic [10:9]  rsvd_10_9;
    logic         spp;
    logic [7:0]   rsvd_7_0;
} mstatus_t;

// One write-data word, seen raw or as mstatus fields.
typedef union packed {
    logic [`XLEN-1:0] raw;
    mstatus_t         mst;
} csr_word_u;

// ----------------------------------------
// Trap result from the ranking logic
// ----------------------------------------
typedef struct packed {
    logic                    trap_en;
    logic [`XLEN-1:0]        cause;
    logic [`IM_ADDR_LEN-1:0] epc;
    logic [`XLEN-1:0]        tval;
} trap_info_t;

endpackage

// File: logic/sys_decode.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module sys_decode
    import cpu_types_pkg::*;
    import csr_pkg::*;
(
    input  logic [`IM_DATA_LEN-1:0] inst,
    input  prv_e                    prv_cur,
    output sys_op_t                 sys_op
);

localparam logic [6:0]              OPC_SYSTEM = 7'b1110011;
localparam logic [6:0]              F7_SFENCE  = 7'b0001001;
localparam logic [`IM_DATA_LEN-1:0] INST_ECALL  = 32'h0000_0073;
localparam logic [`IM_DATA_LEN-1:0] INST_EBREAK = 32'h0010_0073;
localparam logic [`IM_DATA_LEN-1:0] INST_MRET   = 32'h3020_0073;
localparam logic [`IM_DATA_LEN-1:0] INST_SRET   = 32'h1020_0073;

logic [6:0]               opcode;
logic [2:0]               funct3;
logic [6:0]               funct7;
logic [4:0]               rd;
logic [`CSR_ADDR_LEN-1:0] csr_addr;
logic                     csr_known;
logic                     csr_ro;
logic                     csr_prv_low;

assign opcode   = inst[6:0];
assign rd       = inst[11:7];
assign funct3   = inst[14:12];
assign funct7   = inst[31:25];
assign csr_addr = inst[31:20];

assign csr_known   = csr_addr inside {CSR_MSTATUS, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_SATP};
assign csr_ro      = csr_addr[11:10] == 2'b11;       // Read-only address space.
assign csr_prv_low = prv_cur < prv_e'(csr_addr[9:8]);

always_comb begin
    sys_op          = '0;
    sys_op.csr_addr = csr_addr;
    sys_op.prv_req  = PRV_U;
    if (opcode == OPC_SYSTEM) begin
        case (funct3)
            3'b000: begin
                if (inst == INST_ECALL) begin
                    sys_op.ecall = 1'b1;
                end else if (inst == INST_EBREAK) begin
                    sys_op.ebreak = 1'b1;
                end else if (inst == INST_MRET) begin
                    sys_op.mret    = 1'b1;
                    sys_op.prv_req = PRV_M;
                end else if (inst == INST_SRET) begin
                    sys_op.sret    = 1'b1;
                    sys_op.prv_req = PRV_S;
                end else if (funct7 == F7_SFENCE && rd == 5'd0) begin
                    sys_op.sfence  = 1'b1;
                    sys_op.prv_req = PRV_S;
                end else begin
                    sys_op.ill_inst = 1'b1;
                end
            end
            3'b001: begin                                // csrrw.
                sys_op.csr_wr  = 1'b1;
                sys_op.prv_req = prv_e'(csr_addr[9:8]);
                sys_op.csr_ill = csr_ro || !csr_known || csr_prv_low;
            end
            default: begin
                sys_op.ill_inst = 1'b1;                  // Other CSR forms not supported.
            end
        endcase
    end
end

endmodule

// File: logic/tpu.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module tpu
    import cpu_types_pkg::*;
    import csr_pkg::*;
(
    input  logic        inst_valid,
    input  retire_rec_t rec,
    input  sys_op_t     sys_op,
    input  prv_e        prv_cur,
    input  logic        tvm,
    input  logic        tsr,
    output trap_info_t  trap
);

fault_flags_t flags;
logic         satp_upd;
logic         trap_ill_inst;
logic         if_trap_en;
logic         exe_trap_en;
logic         wb_trap_en;
exc_code_e    cause;

assign flags    = rec.flags;
assign satp_upd = sys_op.csr_wr && sys_op.csr_addr == CSR_SATP;

// ----------------------------------------
// Per-stage trap sources
// ----------------------------------------
assign trap_ill_inst = sys_op.ill_inst || sys_op.csr_ill || prv_cur < sys_op.prv_req ||
                       ((satp_upd || sys_op.sfence) && tvm && prv_cur < PRV_M) ||
                       (sys_op.sret && tsr && prv_cur < PRV_M);

assign if_trap_en  = flags.inst_misaligned | flags.inst_pg_fault | flags.inst_xes_fault;

assign exe_trap_en = trap_ill_inst | sys_op.ebreak | sys_op.ecall;

assign wb_trap_en  = rec.is_ldst &&
                     (flags.load_misaligned  | flags.load_pg_fault  | flags.load_xes_fault |
                      flags.store_misaligned | flags.store_pg_fault | flags.store_xes_fault);

assign trap.trap_en = (inst_valid && (if_trap_en || exe_trap_en)) || wb_trap_en;

// ----------------------------------------
// Cause ranking
// ----------------------------------------
always_comb begin
    cause = EXC_INST_MISALIGNED;
    if (wb_trap_en) begin
        if (flags.store_misaligned) begin
            cause = EXC_STORE_MISALIGNED;
        end else if (flags.load_misaligned) begin
            cause = EXC_LOAD_MISALIGNED;
        end else if (flags.store_pg_fault) begin
            cause = EXC_STORE_PG_FAULT;
        end else if (flags.load_pg_fault) begin
            cause = EXC_LOAD_PG_FAULT;
        end else if (flags.store_xes_fault) begin
            cause = EXC_STORE_XES_FAULT;
        end else begin
            cause = EXC_LOAD_XES_FAULT;
        end
    end else if (if_trap_en) begin
        if (flags.inst_misaligned) begin
            cause = EXC_INST_MISALIGNED;
        end else if (flags.inst_pg_fault) begin
            cause = EXC_INST_PG_FAULT;
        end else begin
            cause = EXC_INST_XES_FAULT;
        end
    end else if (exe_trap_en) begin
        if (trap_ill_inst) begin
            cause = EXC_ILL_INST;
        end else if (sys_op.ebreak) begin
            cause = EXC_BREAKPOINT;
        end else begin
            case (prv_cur)                               // ecall by origin.
                PRV_U:   cause = EXC_ECALL_U;
                PRV_S:   cause = EXC_ECALL_S;
                default: cause = EXC_ECALL_M;
            endcase
        end
    end
end

assign trap.cause = (wb_trap_en || if_trap_en || exe_trap_en) ? `XLEN'(cause) : '0;

// ----------------------------------------
// Trap value and return address
// ----------------------------------------
assign trap.tval = wb_trap_en            ? rec.ldst_badaddr :
                   flags.inst_misaligned ? rec.exe_pc :
                   if_trap_en            ? rec.inst_badaddr :
                   trap_ill_inst         ? rec.inst :
                                           '0;

assign trap.epc  = wb_trap_en            ? rec.wb_pc :
                   flags.inst_misaligned ? rec.inst_misaligned_epc :
                                           rec.exe_pc;

endmodule

// File: logic/trap_csr.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module trap_csr
    import cpu_types_pkg::*;
    import csr_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  retire_rec_t              rec,
    input  sys_op_t                  sys_op,
    input  trap_info_t               trap,
    output prv_e                     prv_cur,
    output logic                     tvm,
    output logic                     tsr,
    input  logic [`CSR_ADDR_LEN-1:0] csr_raddr,
    output logic [`XLEN-1:0]         csr_rdata,
    output logic                     redirect_valid,
    output logic [`IM_ADDR_LEN-1:0]  redirect_pc,
    input  logic                     redirect_ready
);

prv_e                    prv_q;
mstatus_t                mstatus_q;
logic [`XLEN-1:0]        mepc_q;
logic [`XLEN-1:0]        mcause_q;
logic [`XLEN-1:0]        mtval_q;
logic [`XLEN-1:0]        satp_q;
logic                    redirect_valid_q;
logic [`IM_ADDR_LEN-1:0] redirect_pc_q;
logic                    accept;
csr_word_u               wdata;
mstatus_t                mstatus_wr;

assign in_ready = !redirect_valid_q;                     // Stall while redirect pending.
assign accept   = in_valid && in_ready;

// ----------------------------------------
// mstatus write data
// ----------------------------------------
always_comb begin
    wdata.raw      = rec.rs1_data;
    mstatus_wr     = '0;
    mstatus_wr.tsr = wdata.mst.tsr;
    mstatus_wr.tvm = wdata.mst.tvm;
    mstatus_wr.spp = wdata.mst.spp;
    // MPP is WARL and H is not a legal value.
    mstatus_wr.mpp = (wdata.mst.mpp == PRV_H) ? mstatus_q.mpp : wdata.mst.mpp;
end

// ----------------------------------------
// CSR state and privilege
// ----------------------------------------
always_ff @(posedge clk) begin
    if (rst) begin
        prv_q     <= PRV_M;
        mstatus_q <= '0;
        mepc_q    <= '0;
        mcause_q  <= '0;
        mtval_q   <= '0;
        satp_q    <= '0;
    end else if (accept) begin
        if (trap.trap_en) begin
            mepc_q        <= trap.epc;
            mcause_q      <= trap.cause;
            mtval_q       <= trap.tval;
            mstatus_q.mpp <= prv_q;
            prv_q         <= PRV_M;
        end else if (sys_op.mret) begin
            prv_q         <= prv_e'(mstatus_q.mpp);
            mstatus_q.mpp <= PRV_U;
        end else if (sys_op.csr_wr) begin
            case (sys_op.csr_addr)
                CSR_MSTATUS: mstatus_q <= mstatus_wr;
                CSR_MEPC:    mepc_q    <= wdata.raw;
                CSR_MCAUSE:  mcause_q  <= wdata.raw;
                CSR_MTVAL:   mtval_q   <= wdata.raw;
                CSR_SATP:    satp_q    <= wdata.raw;
                default:     ;
            endcase
        end
    end
end

// ----------------------------------------
// Redirect to fetch
// ----------------------------------------
always_ff @(posedge clk) begin
    if (rst) begin
        redirect_valid_q <= 1'b0;
        redirect_pc_q    <= `RESET_PC;
    end else if (accept && trap.trap_en) begin
        redirect_valid_q <= 1'b1;
        redirect_pc_q    <= `TRAP_VECTOR;
    end else if (accept && sys_op.mret) begin
        redirect_valid_q <= 1'b1;
        redirect_pc_q    <= mepc_q;
    end else if (redirect_valid_q && redirect_ready) begin
        redirect_valid_q <= 1'b0;                       // Handshake done.
    end
end

always_comb begin
    case (csr_raddr)
        CSR_MSTATUS: csr_rdata = mstatus_q;
        CSR_MEPC:    csr_rdata = mepc_q;
        CSR_MCAUSE:  csr_rdata = mcause_q;
        CSR_MTVAL:   csr_rdata = mtval_q;
        CSR_SATP:    csr_rdata = satp_q;
        default:     csr_rdata = '0;
    endcase
end

assign prv_cur        = prv_q;
assign tvm            = mstatus_q.tvm;
assign tsr            = mstatus_q.tsr;
assign redirect_valid = redirect_valid_q;
assign redirect_pc    = redirect_pc_q;

endmodule

// File: logic/trap_sys.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module trap_sys
    import cpu_types_pkg::*;
    import csr_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  retire_rec_t              rec,
    input  logic [`CSR_ADDR_LEN-1:0] csr_raddr,
    output logic [`XLEN-1:0]         csr_rdata,
    output logic                     redirect_valid,
    output logic [`IM_ADDR_LEN-1:0]  redirect_pc,
    input  logic                     redirect_ready
);

sys_op_t    sys_op;
trap_info_t trap;
prv_e       prv_cur;
logic       tvm;
logic       tsr;

// ----------------------------------------
// Decode and ranking in the same cycle
// ----------------------------------------
sys_decode i_sys_decode (
    .inst    (rec.inst),
    .prv_cur (prv_cur),
    .sys_op  (sys_op)
);

tpu i_tpu (
    .inst_valid (in_valid),
    .rec        (rec),
    .sys_op     (sys_op),
    .prv_cur    (prv_cur),
    .tvm        (tvm),
    .tsr        (tsr),
    .trap       (trap)
);

trap_csr i_trap_csr (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .rec            (rec),
    .sys_op         (sys_op),
    .trap           (trap),
    .prv_cur        (prv_cur),
    .tvm            (tvm),
    .tsr            (tsr),
    .csr_raddr      (csr_raddr),
    .csr_rdata      (csr_rdata),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .redirect_ready (redirect_ready)
);

endmodule

// File: bench/trap_sys_asserts.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module trap_sys_asserts (
    input logic                    clk,
    input logic                    rst,
    input logic                    in_ready,
    input logic                    redirect_valid,
    input logic [`IM_ADDR_LEN-1:0] redirect_pc,
    input logic                    redirect_ready
);

int unsigned fail_count = 0;

// ----------------------------------------
// Redirect handshake
// ----------------------------------------
a_redirect_hold: assert property (@(posedge clk) disable iff (rst)
    redirect_valid && !redirect_ready |=> redirect_valid && $stable(redirect_pc))
else begin
    fail_count++;
    $error("redirect dropped or changed before redirect_ready");
end

a_stall_on_redirect: assert property (@(posedge clk) disable iff (rst)
    redirect_valid |-> !in_ready)
else begin
    fail_count++;
    $error("in_ready high while a redirect is pending");
end

// Idle outputs right after reset.
a_reset_idle: assert property (@(posedge clk)
    $past(rst) |-> !redirect_valid && in_ready)
else begin
    fail_count++;
    $error("outputs active in the cycle after reset");
end

endmodule

// File: bench/trap_sys_tb.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module trap_sys_tb
    import cpu_types_pkg::*;
    import csr_pkg::*;
();

localparam logic [31:0] ECALL     = 32'h0000_0073;
localparam logic [31:0] EBREAK    = 32'h0010_0073;
localparam logic [31:0] MRET      = 32'h3020_0073;
localparam logic [31:0] SRET      = 32'h1020_0073;
localparam logic [31:0] SFENCE    = 32'h1200_0073;
localparam int          N_RANDOM  = 400;
localparam int          N_RECORDS = N_RANDOM + 40;
localparam logic [5:0][11:0] CSR_LIST = {12'h300, 12'h341, 12'h342, 12'h343, 12'h180, 12'hC00};

logic        clk;
logic        rst;
logic        in_valid;
logic        in_ready;
retire_rec_t rec;
logic [11:0] csr_raddr;
logic [31:0] csr_rdata;
logic        redirect_valid;
logic [31:0] redirect_pc;
logic        redirect_ready;
logic [31:0] seed;
int          n_checks;
int          n_errors;

// Reference model state.
logic [1:0]  m_prv;
logic [1:0]  m_mpp;
logic        m_spp;
logic        m_tvm;
logic        m_tsr;
logic [31:0] m_mepc;
logic [31:0] m_mcause;
logic [31:0] m_mtval;
logic [31:0] m_satp;
logic        m_redirect;           // Redirect expected and not yet taken.
logic [31:0] m_redirect_pc;

trap_sys i_dut (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .rec            (rec),
    .csr_raddr      (csr_raddr),
    .csr_rdata      (csr_rdata),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .redirect_ready (redirect_ready)
);

bind trap_sys trap_sys_asserts i_trap_sys_asserts (
    .clk            (clk),
    .rst            (rst),
    .in_ready       (in_ready),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .redirect_ready (redirect_ready)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

// ----------------------------------------
// Helpers
// ----------------------------------------
function automatic logic [31:0] xorshift();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
endfunction

function automatic logic [31:0] csrrw(input logic [11:0] addr);
    return {addr, 5'd1, 3'b001, 5'd1, 7'h73};
endfunction

function automatic logic [31:0] mstatus_word();
    return {9'd0, m_tsr, 1'b0, m_tvm, 7'd0, m_mpp, 2'd0, m_spp, 8'd0};
endfunction

function automatic retire_rec_t make_rec(input logic [31:0] inst, input logic [31:0] rs1);
    retire_rec_t r;
    r.inst                = inst;
    r.exe_pc              = xorshift();
    r.wb_pc               = xorshift();
    r.inst_misaligned_epc = xorshift();
    r.inst_badaddr        = xorshift();
    r.ldst_badaddr        = xorshift();
    r.rs1_data            = rs1;
    r.is_ldst             = 1'b0;
    r.flags               = '0;
    return r;
endfunction

function automatic retire_rec_t random_rec();
    retire_rec_t r;
    logic [31:0] inst;
    logic [31:0] bits;
    case (xorshift() % 10)
        0:       inst = ECALL;
        1:       inst = EBREAK;
        2, 3:    inst = MRET;
        4:       inst = SRET;
        5:       inst = SFENCE | (xorshift() & 32'h01ff_8000);   // Random rs1 and rs2.
        6, 7:    inst = csrrw(CSR_LIST[xorshift() % 6]);
        8:       inst = xorshift();
        default: inst = 32'h0000_0013;                           // Plain ALU op.
    endcase
    r = make_rec(inst, xorshift());
    if (xorshift() % 2 == 0) begin
        bits      = xorshift() & xorshift() & xorshift();
        r.flags   = bits[8:0];
        r.is_ldst = xorshift() % 2 == 1;
    end
    return r;
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic check_csr(input logic [11:0] addr, input logic [31:0] exp, input string name);
    csr_raddr = addr;
    #0.5;
    check(name, csr_rdata, exp);
endtask

// ----------------------------------------
// Reference model for one accepted record
// ----------------------------------------
task automatic model_accept(input retire_rec_t r);
    fault_flags_t f;
    logic [11:0]  addr;
    logic [1:0]   req;
    logic         csrw;
    logic         sfence;
    logic         ill;
    logic         illegal;
    logic         mem_fault;
    logic         fetch_fault;
    logic [31:0]  cause;
    logic [31:0]  epc;
    logic [31:0]  tval;
    f      = r.flags;
    addr   = r.inst[31:20];
    csrw   = r.inst[6:0] == 7'h73 && r.inst[14:12] == 3'b001;
    sfence = r.inst[6:0] == 7'h73 && r.inst[14:12] == 3'b000 &&
             r.inst[31:25] == 7'h09 && r.inst[11:7] == 5'd0;
    ill    = r.inst[6:0] == 7'h73 && !csrw && !sfence &&
             !(r.inst inside {ECALL, EBREAK, MRET, SRET});
    req    = (r.inst == MRET) ? 2'd3 : (r.inst == SRET || sfence) ? 2'd1 :
             csrw ? addr[9:8] : 2'd0;
    illegal = ill || m_prv < req ||
              (csrw && (addr[11:10] == 2'b11 ||
                        !(addr inside {CSR_MSTATUS, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_SATP}))) ||
              (m_tvm && m_prv != 2'd3 && (sfence || (csrw && addr == CSR_SATP))) ||
              (m_tsr && m_prv != 2'd3 && r.inst == SRET);
    mem_fault   = r.is_ldst && (f.load_misaligned || f.load_pg_fault || f.load_xes_fault ||
                  f.store_misaligned || f.store_pg_fault || f.store_xes_fault);
    fetch_fault = f.inst_misaligned || f.inst_pg_fault || f.inst_xes_fault;
    epc  = r.exe_pc;
    tval = 32'd0;
    if (mem_fault) begin                                   // Memory stage ranks first.
        epc   = r.wb_pc;
        tval  = r.ldst_badaddr;
        cause = f.store_misaligned ? 6 : f.load_misaligned ? 4 : f.store_pg_fault ? 15 :
                f.load_pg_fault ? 13 : f.store_xes_fault ? 7 : 5;
    end else if (f.inst_misaligned) begin
        epc   = r.inst_misaligned_epc;
        tval  = r.exe_pc;
        cause = 0;
    end else if (fetch_fault) begin
        tval  = r.inst_badaddr;
        cause = f.inst_pg_fault ? 12 : 1;
    end else if (illegal) begin
        tval  = r.inst;
        cause = 2;
    end else if (r.inst == EBREAK) begin
        cause = 3;
    end else begin
        cause = (m_prv == 2'd0) ? 8 : (m_prv == 2'd1) ? 9 : 11;
    end
    m_redirect = 1'b0;
    if (mem_fault || fetch_fault || illegal || r.inst == EBREAK || r.inst == ECALL) begin
        m_mepc        = epc;
        m_mcause      = cause;
        m_mtval       = tval;
        m_mpp         = m_prv;
        m_prv         = 2'd3;
        m_redirect    = 1'b1;
        m_redirect_pc = `TRAP_VECTOR;
    end else if (r.inst == MRET) begin
        m_redirect    = 1'b1;
        m_redirect_pc = m_mepc;
        m_prv         = m_mpp;
        m_mpp         = 2'd0;
    end else if (csrw) begin
        case (addr)
            CSR_MSTATUS: begin
                m_tsr = r.rs1_data[22];
                m_tvm = r.rs1_data[20];
                m_spp = r.rs1_data[8];
                if (r.rs1_data[12:11] != 2'd2) begin
                    m_mpp = r.rs1_data[12:11];             // H is not a legal MPP.
                end
            end
            CSR_MEPC:   m_mepc   = r.rs1_data;
            CSR_MCAUSE: m_mcause = r.rs1_data;
            CSR_MTVAL:  m_mtval  = r.rs1_data;
            CSR_SATP:   m_satp   = r.rs1_data;
            default:    ;
        endcase
    end
endtask

// ----------------------------------------
// Record handshake and checks
// ----------------------------------------
task automatic send_record(input retire_rec_t r);
    @(negedge clk);
    rec      = r;
    in_valid = 1'b1;
    while (!in_ready) begin
        if (!m_redirect) begin
            n_errors++;
            $display("Error at %0t: in_ready is low with no redirect pending", $time);
        end
        check("redirect_valid", redirect_valid, 32'd1);
        check("redirect_pc", redirect_pc, m_redirect_pc);
        redirect_ready = xorshift() % 4 == 0;              // Random back-pressure.
        if (redirect_ready) begin
            m_redirect = 1'b0;
        end
        @(negedge clk);
    end
    redirect_ready = 1'b0;
    if (m_redirect) begin
        n_errors++;
        $display("Error at %0t: record accepted before the redirect handshake", $time);
    end
    model_accept(r);
    @(negedge clk);
    in_valid = 1'b0;
    check("redirect_valid", redirect_valid, m_redirect);
    if (m_redirect) begin
        check("redirect_pc", redirect_pc, m_redirect_pc);
    end
    check_csr(CSR_MSTATUS, mstatus_word(), "mstatus");
    check_csr(CSR_MEPC, m_mepc, "mepc");
    check_csr(CSR_MCAUSE, m_mcause, "mcause");
    check_csr(CSR_MTVAL, m_mtval, "mtval");
    check_csr(CSR_SATP, m_satp, "satp");
endtask

task automatic expect_illegal(input logic [31:0] inst, input logic [31:0] rs1);
    send_record(make_rec(inst, rs1));
    check_csr(CSR_MCAUSE, 32'd2, "mcause");
    check_csr(CSR_MTVAL, inst, "mtval");
endtask

// ----------------------------------------
// Main sequence
// ----------------------------------------
initial begin
    seed           = 32'd98;
    rst            = 1'b1;
    in_valid       = 1'b0;
    rec            = '0;
    csr_raddr      = '0;
    redirect_ready = 1'b0;
    n_checks       = 0;
    n_errors       = 0;
    m_prv          = 2'd3;
    m_mpp          = 2'd0;
    m_spp          = 1'b0;
    m_tvm          = 1'b0;
    m_tsr          = 1'b0;
    m_mepc         = '0;
    m_mcause       = '0;
    m_mtval        = '0;
    m_satp         = '0;
    m_redirect     = 1'b0;
    m_redirect_pc  = `RESET_PC;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check("in_ready", in_ready, 32'd1);
    check("redirect_valid", redirect_valid, 32'd0);
    check_csr(CSR_MSTATUS, 32'd0, "mstatus");
    check_csr(CSR_MEPC, 32'd0, "mepc");
    check_csr(CSR_MCAUSE, 32'd0, "mcause");
    check_csr(CSR_MTVAL, 32'd0, "mtval");
    check_csr(CSR_SATP, 32'd0, "satp");

    // ecall from M, S and U.
    send_record(make_rec(ECALL, 32'd0));
    check_csr(CSR_MCAUSE, 32'd11, "mcause");
    send_record(make_rec(csrrw(CSR_MSTATUS), 32'h0000_0800));
    send_record(make_rec(MRET, 32'd0));
    send_record(make_rec(ECALL, 32'd0));
    check_csr(CSR_MCAUSE, 32'd9, "mcause");
    send_record(make_rec(csrrw(CSR_MSTATUS), 32'd0));
    send_record(make_rec(MRET, 32'd0));
    send_record(make_rec(ECALL, 32'd0));
    check_csr(CSR_MCAUSE, 32'd8, "mcause");

    // Illegal accesses.
    send_record(make_rec(MRET, 32'd0));
    expect_illegal(csrrw(CSR_MSTATUS), 32'hffff_ffff);
    expect_illegal(csrrw(12'hC00), 32'hffff_ffff);
    send_record(make_rec(csrrw(CSR_MSTATUS), 32'h0050_0800));   // TSR, TVM, MPP = S.
    send_record(make_rec(MRET, 32'd0));
    expect_illegal(SRET, 32'd0);
    send_record(make_rec(MRET, 32'd0));
    expect_illegal(csrrw(CSR_SATP), 32'h8000_1234);
    send_record(make_rec(MRET, 32'd0));
    expect_illegal(SFENCE, 32'd0);

    // csrrw from M reads back.
    send_record(make_rec(csrrw(CSR_MSTATUS), 32'hffff_ffff));
    check_csr(CSR_MSTATUS, 32'h0050_1900, "mstatus");
    send_record(make_rec(csrrw(CSR_MEPC), xorshift()));
    send_record(make_rec(csrrw(CSR_MCAUSE), xorshift()));
    send_record(make_rec(csrrw(CSR_MTVAL), xorshift()));
    send_record(make_rec(csrrw(CSR_SATP), xorshift()));
    send_record(make_rec(csrrw(CSR_MSTATUS), 32'd0));

    repeat (N_RANDOM) begin
        send_record(random_rec());
    end

    @(negedge clk);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             n_checks, n_errors, i_dut.i_trap_sys_asserts.fail_count);
    if (n_errors == 0 && i_dut.i_trap_sys_asserts.fail_count == 0) begin
        $display("** PASS **");
    end else begin
        $display("** FAIL **");
    end
    $finish;
end

initial begin
    repeat (N_RECORDS * 20 + 200) @(posedge clk);
    $display("Timeout: the run did not finish in %0d cycles", N_RECORDS * 20 + 200);
    $display("** FAIL **");
    $finish;
end

endmodule

// File: filelist.f
+incdir+logic
logic/cpu_types_pkg.sv
logic/csr_pkg.sv
logic/sys_decode.sv
logic/tpu.sv
logic/trap_csr.sv
logic/trap_sys.sv
bench/trap_sys_asserts.sv
bench/trap_sys_tb.sv

// File: Bender.yml
package:
  name: trap_sys

export_include_dirs:
  - logic

sources:
  - logic/cpu_types_pkg.sv
  - logic/csr_pkg.sv
  - logic/sys_decode.sv
  - logic/tpu.sv
  - logic/trap_csr.sv
  - logic/trap_sys.sv
  - target: test
    files:
      - bench/trap_sys_asserts.sv
      - bench/trap_sys_tb.sv
